//--- Bender.yml
package:
  name: spi_host

export_include_dirs:
  - include

sources:
  - hdl/spi_host_pkg.sv
  - hdl/spi_host_cmd_queue.sv
  - hdl/spi_host_data_fifos.sv
  - hdl/spi_host_core.sv
  - hdl/spi_host_irq.sv
  - hdl/spi_host.sv
  - target: test
    files:
      - verif/tb_spi_host.sv

//--- hdl/spi_host.sv
// SPI host top: command validation, FIFO error detection and block interconnect
`timescale 1ns/10ps
`include "spi_host_config.svh"

module spi_host (
  input  logic                      clk_i,
  input  logic                      rst_ni,
  input  logic                      spien_i,
  input  logic                      sw_rst_i,
  input  logic                      cmd_valid_i,
  input  logic [`SPI_CSW-1:0]       csid_i,
  input  logic [`SPI_LEN_W-1:0]     cmd_len_i,
  input  spi_host_pkg::spi_dir_e    cmd_dir_i,
  input  logic                      cmd_csaat_i,
  input  logic [`SPI_CLKDIV_W-1:0]  clkdiv_i,
  input  logic [`SPI_CS_TIME_W-1:0] csnlead_i,
  input  logic [`SPI_CS_TIME_W-1:0] csntrail_i,
  input  logic [`SPI_CS_TIME_W-1:0] csnidle_i,
  input  logic                      cpol_i,
  input  logic                      cpha_i,
  input  logic [7:0]                tx_data_i,
  input  logic                      tx_valid_i,
  input  logic                      rx_re_i,
  output logic [7:0]                rx_data_o,
  input  logic [`SPI_QD_W-1:0]      tx_wm_lvl_i,
  input  logic [`SPI_QD_W-1:0]      rx_wm_lvl_i,
  input  logic [4:0]                err_en_i,
  input  logic [5:0]                evt_en_i,
  input  logic                      err_clear_i,
  input  logic                      evt_clear_i,
  output logic                      sck_o,
  output logic [`SPI_NUM_CS-1:0]    csb_o,
  output logic                      sd_o,
  output logic                      sd_en_o,
  input  logic                      sd_i,
  output logic                      ready_o,
  output logic                      active_o,
  output logic [`SPI_QD_W-1:0]      tx_qd_o,
  output logic [`SPI_QD_W-1:0]      rx_qd_o,
  output logic [4:0]                err_status_o,
  output logic                      intr_error_o,
  output logic                      intr_event_o
);

  logic [`SPI_CSW-1:0]       q_csid;
  logic [`SPI_LEN_W-1:0]     q_len;
  spi_host_pkg::spi_dir_e    q_dir;
  logic [`SPI_CLKDIV_W-1:0]  q_clkdiv;
  logic [`SPI_CS_TIME_W-1:0] q_csnlead, q_csntrail, q_csnidle;
  logic q_csaat, q_cpol, q_cpha, q_valid, q_ready;
  logic csid_inval, cmd_inval, cmd_busy, err_busy, overflow, underflow, core_en;
  logic tx_empty, tx_full, rx_empty, rx_full, tx_wm, rx_wm;
  logic tx_pop, rx_push, tx_stall, rx_stall;
  logic [7:0] tx_head, rx_byte;

  assign csid_inval = cmd_valid_i & (csid_i >= `SPI_CSW'(`SPI_NUM_CS));
  assign cmd_inval  = cmd_valid_i & (cmd_dir_i == spi_host_pkg::DirDummy);
  assign overflow   = tx_valid_i & tx_full;
  assign underflow  = rx_re_i & rx_empty;
  assign ready_o    = ~cmd_busy;
  // Any recorded error halts the engine until cleared
  assign core_en    = spien_i & ~(|err_status_o);

  spi_host_cmd_queue i_cmd_queue (
    .clk_i, .rst_ni, .sw_rst_i,
    .cmd_push_i    (cmd_valid_i & ~csid_inval & ~cmd_inval),
    .cmd_csid_i    (csid_i),     .cmd_len_i      (cmd_len_i),  .cmd_dir_i     (cmd_dir_i),
    .cmd_csaat_i   (cmd_csaat_i), .cmd_clkdiv_i  (clkdiv_i),   .cmd_csnlead_i (csnlead_i),
    .cmd_csntrail_i (csntrail_i), .cmd_csnidle_i (csnidle_i),  .cmd_cpol_i    (cpol_i),
    .cmd_cpha_i    (cpha_i),
    .cmd_valid_o   (q_valid),    .cmd_ready_i    (q_ready),
    .cmd_csid_o    (q_csid),     .cmd_len_o      (q_len),      .cmd_dir_o     (q_dir),
    .cmd_csaat_o   (q_csaat),    .cmd_clkdiv_o   (q_clkdiv),   .cmd_csnlead_o (q_csnlead),
    .cmd_csntrail_o (q_csntrail), .cmd_csnidle_o (q_csnidle),  .cmd_cpol_o    (q_cpol),
    .cmd_cpha_o    (q_cpha),
    .busy_o        (cmd_busy),   .err_busy_o     (err_busy)
  );

  spi_host_data_fifos i_data_fifos (
    .clk_i, .rst_ni, .sw_rst_i,
    .tx_push_i  (tx_valid_i & ~overflow), .tx_data_i (tx_data_i),
    .tx_pop_i   (tx_pop),                 .tx_head_o (tx_head),
    .rx_push_i  (rx_push),                .rx_data_i (rx_byte),
    .rx_pop_i   (rx_re_i & ~underflow),   .rx_head_o (rx_data_o),
    .tx_wm_lvl_i, .rx_wm_lvl_i, .tx_qd_o, .rx_qd_o,
    .tx_empty_o (tx_empty), .tx_full_o (tx_full), .rx_empty_o (rx_empty),
    .rx_full_o  (rx_full),  .tx_wm_o   (tx_wm),   .rx_wm_o    (rx_wm)
  );

  spi_host_core i_core (
    .clk_i, .rst_ni, .sw_rst_i,
    .en_i           (core_en),
    .cmd_csid_i     (q_csid),     .cmd_len_i     (q_len),     .cmd_dir_i     (q_dir),
    .cmd_csaat_i    (q_csaat),    .cmd_clkdiv_i  (q_clkdiv),  .cmd_csnlead_i (q_csnlead),
    .cmd_csntrail_i (q_csntrail), .cmd_csnidle_i (q_csnidle), .cmd_cpol_i    (q_cpol),
    .cmd_cpha_i     (q_cpha),     .cmd_valid_i   (q_valid),   .cmd_ready_o   (q_ready),
    .tx_byte_i  (tx_head), .tx_empty_i (tx_empty), .tx_pop_o  (tx_pop),
    .rx_byte_o  (rx_byte), .rx_full_i  (rx_full),  .rx_push_o (rx_push),
    .sck_o, .csb_o, .sd_o, .sd_en_o, .sd_i, .active_o,
    .tx_stall_o (tx_stall), .rx_stall_o (rx_stall)
  );

  // Stalls are level conditions; flag them through the TX/RX event enables
  spi_host_irq i_irq (
    .clk_i, .rst_ni,
    .err_vec_i   ({csid_inval, cmd_inval, underflow, overflow, err_busy}),
    .err_en_i, .err_clear_i,
    .idle_i      (~active_o),
    .ready_i     (~cmd_busy),
    .tx_wm_i     (tx_wm | tx_stall),
    .rx_wm_i     (rx_wm | rx_stall),
    .tx_empty_i  (tx_empty),
    .rx_full_i   (rx_full),
    .evt_en_i, .evt_clear_i,
    .err_status_o, .intr_error_o, .intr_event_o
  );

endmodule

//--- hdl/spi_host_cmd_queue.sv
// SPI command FIFO holding validated commands until the shift engine takes them
`timescale 1ns/10ps
`include "spi_host_config.svh"

module spi_host_cmd_queue (
  input  logic                      clk_i,
  input  logic                      rst_ni,
  input  logic                      sw_rst_i,
  input  logic                      cmd_push_i,
  input  logic [`SPI_CSW-1:0]       cmd_csid_i,
  input  logic [`SPI_LEN_W-1:0]     cmd_len_i,
  input  spi_host_pkg::spi_dir_e    cmd_dir_i,
  input  logic                      cmd_csaat_i,
  input  logic [`SPI_CLKDIV_W-1:0]  cmd_clkdiv_i,
  input  logic [`SPI_CS_TIME_W-1:0] cmd_csnlead_i,
  input  logic [`SPI_CS_TIME_W-1:0] cmd_csntrail_i,
  input  logic [`SPI_CS_TIME_W-1:0] cmd_csnidle_i,
  input  logic                      cmd_cpol_i,
  input  logic                      cmd_cpha_i,
  output logic                      cmd_valid_o,
  input  logic                      cmd_ready_i,
  output logic [`SPI_CSW-1:0]       cmd_csid_o,
  output logic [`SPI_LEN_W-1:0]     cmd_len_o,
  output spi_host_pkg::spi_dir_e    cmd_dir_o,
  output logic                      cmd_csaat_o,
  output logic [`SPI_CLKDIV_W-1:0]  cmd_clkdiv_o,
  output logic [`SPI_CS_TIME_W-1:0] cmd_csnlead_o,
  output logic [`SPI_CS_TIME_W-1:0] cmd_csntrail_o,
  output logic [`SPI_CS_TIME_W-1:0] cmd_csnidle_o,
  output logic                      cmd_cpol_o,
  output logic                      cmd_cpha_o,
  output logic                      busy_o,
  output logic                      err_busy_o
);

  localparam int CmdW = `SPI_CSW + `SPI_LEN_W + 3 + `SPI_CLKDIV_W + 3 * `SPI_CS_TIME_W + 2;
  localparam int PtrW = $clog2(`SPI_CMD_DEPTH);
  localparam int CntW = $clog2(`SPI_CMD_DEPTH + 1);

  logic [CmdW-1:0] mem_q [`SPI_CMD_DEPTH];
  logic [CmdW-1:0] wdata;
  logic [PtrW-1:0] wptr_q, rptr_q;
  logic [CntW-1:0] count_q;
  logic [1:0]      dir_bits;
  logic            push, pop;

  assign busy_o      = (count_q == CntW'(`SPI_CMD_DEPTH));
  assign err_busy_o  = cmd_push_i & busy_o;
  assign push        = cmd_push_i & ~busy_o;
  assign cmd_valid_o = (count_q != '0);
  assign pop         = cmd_valid_o & cmd_ready_i;

  assign wdata = {cmd_csid_i, cmd_len_i, cmd_dir_i, cmd_csaat_i, cmd_clkdiv_i,
                  cmd_csnlead_i, cmd_csntrail_i, cmd_csnidle_i, cmd_cpol_i, cmd_cpha_i};
  assign {cmd_csid_o, cmd_len_o, dir_bits, cmd_csaat_o, cmd_clkdiv_o,
          cmd_csnlead_o, cmd_csntrail_o, cmd_csnidle_o, cmd_cpol_o, cmd_cpha_o} = mem_q[rptr_q];
  assign cmd_dir_o = spi_host_pkg::spi_dir_e'(dir_bits);

  always_ff @(posedge clk_i) begin
    if (push) begin
      mem_q[wptr_q] <= wdata;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      wptr_q  <= '0;
      rptr_q  <= '0;
      count_q <= '0;
    end else if (sw_rst_i) begin
      wptr_q  <= '0;
      rptr_q  <= '0;
      count_q <= '0;
    end else begin
      if (push) begin
        wptr_q <= (wptr_q == PtrW'(`SPI_CMD_DEPTH - 1)) ? '0 : wptr_q + 1'b1;
      end
      if (pop) begin
        rptr_q <= (rptr_q == PtrW'(`SPI_CMD_DEPTH - 1)) ? '0 : rptr_q + 1'b1;
      end
      if (push && !pop) begin
        count_q <= count_q + 1'b1;
      end else if (pop && !push) begin
        count_q <= count_q - 1'b1;
      end
    end
  end

endmodule

//--- hdl/spi_host_core.sv
// SPI shift engine sequencing chip select, SCK and serial data for each command
`timescale 1ns/10ps
`include "spi_host_config.svh"

module spi_host_core (
  input  logic                      clk_i,
  input  logic                      rst_ni,
  input  logic                      sw_rst_i,
  input  logic                      en_i,
  input  logic [`SPI_CSW-1:0]       cmd_csid_i,
  input  logic [`SPI_LEN_W-1:0]     cmd_len_i,
  input  spi_host_pkg::spi_dir_e    cmd_dir_i,
  input  logic                      cmd_csaat_i,
  input  logic [`SPI_CLKDIV_W-1:0]  cmd_clkdiv_i,
  input  logic [`SPI_CS_TIME_W-1:0] cmd_csnlead_i,
  input  logic [`SPI_CS_TIME_W-1:0] cmd_csntrail_i,
  input  logic [`SPI_CS_TIME_W-1:0] cmd_csnidle_i,
  input  logic                      cmd_cpol_i,
  input  logic                      cmd_cpha_i,
  input  logic                      cmd_valid_i,
  output logic                      cmd_ready_o,
  input  logic [7:0]                tx_byte_i,
  input  logic                      tx_empty_i,
  output logic                      tx_pop_o,
  output logic [7:0]                rx_byte_o,
  input  logic                      rx_full_i,
  output logic                      rx_push_o,
  output logic                      sck_o,
  output logic [`SPI_NUM_CS-1:0]    csb_o,
  output logic                      sd_o,
  output logic                      sd_en_o,
  input  logic                      sd_i,
  output logic                      active_o,
  output logic                      tx_stall_o,
  output logic                      rx_stall_o
);

  spi_host_pkg::core_state_e state_q;

  logic [`SPI_CSW-1:0]       csid_q;
  logic [`SPI_LEN_W-1:0]     len_q, byte_cnt_q;
  logic [`SPI_CLKDIV_W-1:0]  clkdiv_q, div_cnt_q;
  logic [`SPI_CS_TIME_W-1:0] csnlead_q, csntrail_q, csnidle_q, cs_cnt_q, cs_target;
  logic [2:0]                bit_cnt_q;
  logic [7:0]                tx_sr_q, rx_sr_q;
  logic rd_q, wr_q, csaat_q, cpol_q, cpha_q, half_q, loaded_q, sck_q;
  logic tick, cs_done, cs_on, lead_end, byte_end, last_byte, go;
  logic lead_load, edge_en, edge_lead, edge_trail, accept;

  always_comb begin
    case (state_q)
      spi_host_pkg::StLead:  cs_target = csnlead_q;
      spi_host_pkg::StTrail: cs_target = csntrail_q;
      default:               cs_target = csnidle_q;
    endcase
  end

  assign tick      = (div_cnt_q == clkdiv_q);
  assign cs_done   = (cs_cnt_q == cs_target);
  assign last_byte = (byte_cnt_q == len_q);
  assign lead_end  = (state_q == spi_host_pkg::StLead) & tick & cs_done;
  assign byte_end  = (state_q == spi_host_pkg::StShift) & tick & half_q & (bit_cnt_q == 3'd7);

  // Hold SCK when a byte cannot be fetched or stored
  assign tx_stall_o = en_i & ((lead_end & ~loaded_q) |
                              (byte_end & ~last_byte & wr_q & tx_empty_i));
  assign rx_stall_o = en_i & byte_end & rd_q & rx_full_i;
  assign go         = en_i & ~tx_stall_o & ~rx_stall_o;

  // First byte is fetched any time during the lead, ahead of the first edge
  assign lead_load = en_i & (state_q == spi_host_pkg::StLead) & ~loaded_q &
                     (~wr_q | ~tx_empty_i);
  assign edge_en    = go & tick & ((state_q == spi_host_pkg::StShift) | lead_end);
  assign edge_lead  = edge_en & ~half_q;
  assign edge_trail = edge_en & half_q;

  assign tx_pop_o    = wr_q & (lead_load | (go & byte_end & ~last_byte));
  assign rx_push_o   = rd_q & go & byte_end;
  assign rx_byte_o   = cpha_q ? {rx_sr_q[6:0], sd_i} : rx_sr_q;
  assign cmd_ready_o = (en_i & (state_q == spi_host_pkg::StIdle)) |
                       (go & byte_end & last_byte & csaat_q);
  assign accept      = cmd_valid_i & cmd_ready_o;

  assign cs_on    = (state_q == spi_host_pkg::StLead) | (state_q == spi_host_pkg::StShift) |
                    (state_q == spi_host_pkg::StTrail);
  assign active_o = cs_on;
  assign sck_o    = sck_q;
  assign sd_en_o  = wr_q & loaded_q &
                    ((state_q == spi_host_pkg::StLead) | (state_q == spi_host_pkg::StShift));
  assign sd_o     = sd_en_o & tx_sr_q[7];

  always_comb begin
    for (int i = 0; i < `SPI_NUM_CS; i++) begin
      csb_o[i] = ~(cs_on & (csid_q == `SPI_CSW'(i)));
    end
  end

  // MSB first; CPHA picks which edge samples and which one shifts
  always_ff @(posedge clk_i) begin
    if (lead_load || (edge_trail && bit_cnt_q == 3'd7)) begin
      tx_sr_q <= wr_q ? tx_byte_i : 8'h00;
    end else if ((edge_lead && cpha_q && bit_cnt_q != 3'd0) || (edge_trail && !cpha_q)) begin
      tx_sr_q <= {tx_sr_q[6:0], 1'b0};
    end
    if ((edge_lead && !cpha_q) || (edge_trail && cpha_q)) begin
      rx_sr_q <= {rx_sr_q[6:0], sd_i};
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q    <= spi_host_pkg::StIdle;
      div_cnt_q  <= '0;
      cs_cnt_q   <= '0;
      bit_cnt_q  <= '0;
      byte_cnt_q <= '0;
      half_q     <= 1'b0;
      loaded_q   <= 1'b0;
      sck_q      <= 1'b0;
      csid_q     <= '0;
      len_q      <= '0;
      rd_q       <= 1'b0;
      wr_q       <= 1'b0;
      csaat_q    <= 1'b0;
      clkdiv_q   <= '0;
      csnlead_q  <= '0;
      csntrail_q <= '0;
      csnidle_q  <= '0;
      cpol_q     <= 1'b0;
      cpha_q     <= 1'b0;
    end else if (sw_rst_i) begin
      state_q  <= spi_host_pkg::StIdle;
      loaded_q <= 1'b0;
      sck_q    <= cpol_q;
    end else if (accept) begin
      state_q    <= spi_host_pkg::StLead;
      div_cnt_q  <= '0;
      cs_cnt_q   <= '0;
      bit_cnt_q  <= '0;
      byte_cnt_q <= '0;
      half_q     <= 1'b0;
      loaded_q   <= 1'b0;
      sck_q      <= cmd_cpol_i;
      csid_q     <= cmd_csid_i;
      len_q      <= cmd_len_i;
      rd_q       <= (cmd_dir_i == spi_host_pkg::DirRdOnly) | (cmd_dir_i == spi_host_pkg::DirBidir);
      wr_q       <= (cmd_dir_i == spi_host_pkg::DirWrOnly) | (cmd_dir_i == spi_host_pkg::DirBidir);
      csaat_q    <= cmd_csaat_i;
      clkdiv_q   <= cmd_clkdiv_i;
      csnlead_q  <= cmd_csnlead_i;
      csntrail_q <= cmd_csntrail_i;
      csnidle_q  <= cmd_csnidle_i;
      cpol_q     <= cmd_cpol_i;
      cpha_q     <= cmd_cpha_i;
    end else begin
      if (lead_load) begin
        loaded_q <= 1'b1;
      end
      if (go && state_q != spi_host_pkg::StIdle) begin
        if (!tick) begin
          div_cnt_q <= div_cnt_q + 1'b1;
        end else begin
          div_cnt_q <= '0;
          cs_cnt_q  <= cs_done ? '0 : cs_cnt_q + 1'b1;
          case (state_q)
            spi_host_pkg::StLead:   if (cs_done) state_q <= spi_host_pkg::StShift;
            spi_host_pkg::StTrail:  if (cs_done) state_q <= spi_host_pkg::StIdleCs;
            spi_host_pkg::StIdleCs: if (cs_done) state_q <= spi_host_pkg::StIdle;
            default: begin
            end
          endcase
          if (edge_en) begin
            sck_q  <= ~sck_q;
            half_q <= ~half_q;
            if (half_q) begin
              bit_cnt_q <= bit_cnt_q + 1'b1;
              if (bit_cnt_q == 3'd7) begin
                byte_cnt_q <= byte_cnt_q + 1'b1;
                if (last_byte) begin
                  state_q  <= spi_host_pkg::StTrail;
                  cs_cnt_q <= '0;
                end
              end
            end
          end
        end
      end
    end
  end

endmodule

//--- hdl/spi_host_data_fifos.sv
// SPI transmit and receive byte FIFOs with level, empty, full and watermark flags
`timescale 1ns/10ps
`include "spi_host_config.svh"

module spi_host_data_fifos (
  input  logic                 clk_i,
  input  logic                 rst_ni,
  input  logic                 sw_rst_i,
  input  logic                 tx_push_i,
  input  logic [7:0]           tx_data_i,
  input  logic                 tx_pop_i,
  output logic [7:0]           tx_head_o,
  input  logic                 rx_push_i,
  input  logic [7:0]           rx_data_i,
  input  logic                 rx_pop_i,
  output logic [7:0]           rx_head_o,
  input  logic [`SPI_QD_W-1:0] tx_wm_lvl_i,
  input  logic [`SPI_QD_W-1:0] rx_wm_lvl_i,
  output logic [`SPI_QD_W-1:0] tx_qd_o,
  output logic [`SPI_QD_W-1:0] rx_qd_o,
  output logic                 tx_empty_o,
  output logic                 tx_full_o,
  output logic                 rx_empty_o,
  output logic                 rx_full_o,
  output logic                 tx_wm_o,
  output logic                 rx_wm_o
);

  // Index 0 is the TX FIFO, index 1 the RX FIFO
  logic [1:0]                 push, pop, empty, full;
  logic [1:0][7:0]            din, head;
  logic [1:0][`SPI_QD_W-1:0] level;

  assign push = {rx_push_i, tx_push_i};
  assign pop  = {rx_pop_i, tx_pop_i};
  assign din  = {rx_data_i, tx_data_i};

  for (genvar g = 0; g < 2; g++) begin : gen_fifo
    localparam int Depth = (g == 0) ? `SPI_TX_DEPTH : `SPI_RX_DEPTH;
    localparam int PtrW  = $clog2(Depth);

    logic [7:0]           mem_q [Depth];
    logic [PtrW-1:0]      wptr_q, rptr_q;
    logic [`SPI_QD_W-1:0] cnt_q;
    logic                 do_push, do_pop;

    assign empty[g] = (cnt_q == '0);
    assign full[g]  = (cnt_q == `SPI_QD_W'(Depth));
    assign level[g] = cnt_q;
    assign head[g]  = mem_q[rptr_q];
    assign do_push  = push[g] & ~full[g];
    assign do_pop   = pop[g] & ~empty[g];

    always_ff @(posedge clk_i) begin
      if (do_push) begin
        mem_q[wptr_q] <= din[g];
      end
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
      if (!rst_ni) begin
        wptr_q <= '0;
        rptr_q <= '0;
        cnt_q  <= '0;
      end else if (sw_rst_i) begin
        wptr_q <= '0;
        rptr_q <= '0;
        cnt_q  <= '0;
      end else begin
        if (do_push) begin
          wptr_q <= (wptr_q == PtrW'(Depth - 1)) ? '0 : wptr_q + 1'b1;
        end
        if (do_pop) begin
          rptr_q <= (rptr_q == PtrW'(Depth - 1)) ? '0 : rptr_q + 1'b1;
        end
        cnt_q <= cnt_q + `SPI_QD_W'(do_push) - `SPI_QD_W'(do_pop);
      end
    end
  end

  assign tx_head_o  = head[0];
  assign rx_head_o  = head[1];
  assign tx_qd_o    = level[0];
  assign rx_qd_o    = level[1];
  assign tx_empty_o = empty[0];
  assign rx_empty_o = empty[1];
  assign tx_full_o  = full[0];
  assign rx_full_o  = full[1];

  // TX asks for data below its mark, RX reports at or above its mark
  assign tx_wm_o = (level[0] < tx_wm_lvl_i);
  assign rx_wm_o = (level[1] >= rx_wm_lvl_i);

endmodule

//--- hdl/spi_host_irq.sv
// SPI host sticky error status, event edge detection and the two interrupt lines
`timescale 1ns/10ps

module spi_host_irq (
  input  logic       clk_i,
  input  logic       rst_ni,
  input  logic [4:0] err_vec_i,
  input  logic [4:0] err_en_i,
  input  logic       err_clear_i,
  input  logic       idle_i,
  input  logic       ready_i,
  input  logic       tx_wm_i,
  input  logic       rx_wm_i,
  input  logic       tx_empty_i,
  input  logic       rx_full_i,
  input  logic [5:0] evt_en_i,
  input  logic       evt_clear_i,
  output logic [4:0] err_status_o,
  output logic       intr_error_o,
  output logic       intr_event_o
);

  logic [5:0] cond, cond_q, cond_rise;

  assign cond      = {idle_i, ready_i, tx_wm_i, rx_wm_i, tx_empty_i, rx_full_i};
  assign cond_rise = cond & ~cond_q;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      cond_q       <= '0;
      err_status_o <= '0;
      intr_error_o <= 1'b0;
      intr_event_o <= 1'b0;
    end else begin
      cond_q <= cond;
      // Errors landing on a clear cycle are still kept
      err_status_o <= (err_clear_i ? 5'b0 : err_status_o) | err_vec_i;
      intr_error_o <= (intr_error_o & ~err_clear_i) | (|(err_vec_i & err_en_i));
      intr_event_o <= (intr_event_o & ~evt_clear_i) | (|(cond_rise & evt_en_i));
    end
  end

endmodule

//--- hdl/spi_host_pkg.sv
// SPI host shared types: transfer direction and shift engine states
package spi_host_pkg;

  typedef enum logic [1:0] {
    DirDummy  = 2'd0,
    DirRdOnly = 2'd1,
    DirWrOnly = 2'd2,
    DirBidir  = 2'd3
  } spi_dir_e;

  typedef enum logic [2:0] {
    StIdle   = 3'd0,
    StLead   = 3'd1,
    StShift  = 3'd2,
    StTrail  = 3'd3,
    StIdleCs = 3'd4
  } core_state_e;

endpackage

//--- include/spi_host_config.svh
// SPI host sizing: queue depths, counter widths and chip-select count
`ifndef SPI_HOST_CONFIG_SVH
`define SPI_HOST_CONFIG_SVH

`define SPI_NUM_CS 2
// Wide enough to carry out-of-range chip-select indices
`define SPI_CSW 2

`define SPI_CMD_DEPTH 4
`define SPI_TX_DEPTH 8
`define SPI_RX_DEPTH 8
`define SPI_QD_W 4

// Segment length is the byte count minus one
`define SPI_LEN_W 8
`define SPI_CLKDIV_W 8
`define SPI_CS_TIME_W 4

`endif

//--- verif/tb_spi_host.sv
// Directed testbench for the SPI host with a serial loopback model and FIFO checks
`timescale 1ns/10ps
`include "spi_host_config.svh"

module tb_spi_host;

  localparam int TimeoutCycles = 5000;

  logic                      clk_i;
  logic                      rst_ni;
  logic                      spien_i;
  logic                      sw_rst_i;
  logic                      cmd_valid_i;
  logic [`SPI_CSW-1:0]       csid_i;
  logic [`SPI_LEN_W-1:0]     cmd_len_i;
  spi_host_pkg::spi_dir_e    cmd_dir_i;
  logic                      cmd_csaat_i;
  logic [`SPI_CLKDIV_W-1:0]  clkdiv_i;
  logic [`SPI_CS_TIME_W-1:0] csnlead_i, csntrail_i, csnidle_i;
  logic                      cpol_i, cpha_i;
  logic [7:0]                tx_data_i, rx_data_o;
  logic                      tx_valid_i, rx_re_i;
  logic [`SPI_QD_W-1:0]      tx_wm_lvl_i, rx_wm_lvl_i, tx_qd_o, rx_qd_o;
  logic [4:0]                err_en_i, err_status_o;
  logic [5:0]                evt_en_i;
  logic                      err_clear_i, evt_clear_i;
  logic                      sck_o, sd_o, sd_en_o, sd_i;
  logic [`SPI_NUM_CS-1:0]    csb_o;
  logic                      ready_o, active_o, intr_error_o, intr_event_o;

  int                     errors;
  int                     checks;
  int                     cs_starts;
  logic [31:0]            lcg_state;
  logic                   sampled [$];
  logic                   prev_sck, prev_sd, cur_cpol, cur_cpha;
  logic                   active_seen, sd_en_seen, rx_seen;
  logic [`SPI_NUM_CS-1:0] prev_csb, csb_low_seen;

  // Serial loopback
  assign sd_i = sd_o;

  spi_host i_dut (
    .clk_i, .rst_ni, .spien_i, .sw_rst_i, .cmd_valid_i, .csid_i, .cmd_len_i, .cmd_dir_i,
    .cmd_csaat_i, .clkdiv_i, .csnlead_i, .csntrail_i, .csnidle_i, .cpol_i, .cpha_i,
    .tx_data_i, .tx_valid_i, .rx_re_i, .rx_data_o, .tx_wm_lvl_i, .rx_wm_lvl_i,
    .err_en_i, .evt_en_i, .err_clear_i, .evt_clear_i, .sck_o, .csb_o, .sd_o, .sd_en_o,
    .sd_i, .ready_o, .active_o, .tx_qd_o, .rx_qd_o, .err_status_o, .intr_error_o,
    .intr_event_o
  );

  initial begin
    clk_i = 1'b0;
    forever #5 clk_i = ~clk_i;
  end

  // Capture edge is rising when CPOL equals CPHA; take the value held before the edge
  always @(negedge clk_i) begin
    if (!(&prev_csb) && !(&csb_o) && (sck_o != prev_sck) &&
        (sck_o == (cur_cpol == cur_cpha))) begin
      sampled.push_back(prev_sd);
    end
    if ((&prev_csb) && !(&csb_o)) begin
      cs_starts++;
    end
    csb_low_seen = csb_low_seen | ~csb_o;
    active_seen  = active_seen | active_o;
    sd_en_seen   = sd_en_seen | sd_en_o;
    rx_seen      = rx_seen | (rx_qd_o != '0);
    prev_sck     = sck_o;
    prev_sd      = sd_o;
    prev_csb     = csb_o;
  end

  function automatic logic [7:0] next_random();
    lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
    return lcg_state[23:16];
  endfunction

  task automatic compare(input string name, input logic [31:0] got, input logic [31:0] exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("FAIL t=%0t %s: got 0x%0h, expected 0x%0h", $time, name, got, exp);
    end
  endtask

  task automatic await_active(input logic level, input string what);
    int n;
    n = 0;
    while (active_o !== level && n < TimeoutCycles) begin
      @(negedge clk_i);
      n++;
    end
    if (active_o !== level) begin
      errors++;
      $display("Timeout at %0t: active_o never went to %0b while waiting for %s",
               $time, level, what);
    end
  endtask

  task automatic reset_observers();
    sampled.delete();
    cs_starts    = 0;
    csb_low_seen = '0;
    active_seen  = 1'b0;
    sd_en_seen   = 1'b0;
    rx_seen      = 1'b0;
  endtask

  task automatic push_tx(input logic [7:0] data);
    @(negedge clk_i);
    tx_data_i  = data;
    tx_valid_i = 1'b1;
    @(negedge clk_i);
    tx_valid_i = 1'b0;
  endtask

  // Head byte is shown before the pop edge
  task automatic read_rx(output logic [7:0] data);
    @(negedge clk_i);
    data    = rx_data_o;
    rx_re_i = 1'b1;
    @(negedge clk_i);
    rx_re_i = 1'b0;
  endtask

  task automatic issue_cmd(input logic [`SPI_CSW-1:0] csid, input logic [`SPI_LEN_W-1:0] len,
                           input spi_host_pkg::spi_dir_e dir, input logic cpol,
                           input logic cpha);
    @(negedge clk_i);
    csid_i      = csid;
    cmd_len_i   = len;
    cmd_dir_i   = dir;
    cpol_i      = cpol;
    cpha_i      = cpha;
    cur_cpol    = cpol;
    cur_cpha    = cpha;
    cmd_valid_i = 1'b1;
    @(negedge clk_i);
    cmd_valid_i = 1'b0;
  endtask

  task automatic pulse_ctrl(input logic err_clr, input logic evt_clr, input logic swr);
    @(negedge clk_i);
    err_clear_i = err_clr;
    evt_clear_i = evt_clr;
    sw_rst_i    = swr;
    @(negedge clk_i);
    err_clear_i = 1'b0;
    evt_clear_i = 1'b0;
    sw_rst_i    = 1'b0;
  endtask

  task automatic send_bytes(input int n, input logic [`SPI_CSW-1:0] csid,
                            input spi_host_pkg::spi_dir_e dir, input logic cpol,
                            input logic cpha);
    logic [7:0] exp_q [$];
    logic [7:0] got;
    for (int i = 0; i < n; i++) begin
      exp_q.push_back(next_random());
      push_tx(exp_q[i]);
    end
    reset_observers();
    issue_cmd(csid, `SPI_LEN_W'(n - 1), dir, cpol, cpha);
    await_active(1'b1, "the transfer to start");
    await_active(1'b0, "the transfer to end");
    compare("csb_o low lines", csb_low_seen, 32'(1) << csid);
    compare("sck_o idle level", sck_o, cpol);
    compare("sampled bit count", sampled.size(), n * 8);
    if (sampled.size() == n * 8) begin
      for (int i = 0; i < n; i++) begin
        got = '0;
        for (int b = 0; b < 8; b++) begin
          got = {got[6:0], sampled[i * 8 + b]};
        end
        compare($sformatf("sd_o byte %0d", i), got, exp_q[i]);
      end
    end
    if (dir == spi_host_pkg::DirBidir) begin
      for (int i = 0; i < n; i++) begin
        read_rx(got);
        compare($sformatf("rx_data_o byte %0d", i), got, exp_q[i]);
      end
    end else begin
      compare("rx_qd_o nonzero seen", rx_seen, 0);
    end
  endtask

  task automatic receive_zeros(input int n);
    logic [7:0] got;
    reset_observers();
    issue_cmd('0, `SPI_LEN_W'(n - 1), spi_host_pkg::DirRdOnly, 1'b0, 1'b0);
    await_active(1'b1, "the read to start");
    await_active(1'b0, "the read to end");
    compare("sd_en_o high seen", sd_en_seen, 0);
    for (int i = 0; i < n; i++) begin
      read_rx(got);
      compare($sformatf("rx_data_o byte %0d", i), got, 0);
    end
  endtask

  task automatic reject_bad_cmds();
    logic [7:0] got;
    err_en_i = 5'h1f;
    reset_observers();
    issue_cmd(2'd3, '0, spi_host_pkg::DirRdOnly, 1'b0, 1'b0);
    compare("err_status_o after csid 3", err_status_o, 5'b10000);
    compare("intr_error_o after csid 3", intr_error_o, 1);
    pulse_ctrl(1'b1, 1'b0, 1'b0);
    compare("err_status_o after clear", err_status_o, 0);
    compare("intr_error_o after clear", intr_error_o, 0);
    issue_cmd('0, '0, spi_host_pkg::DirDummy, 1'b0, 1'b0);
    compare("err_status_o after dummy", err_status_o, 5'b01000);
    compare("intr_error_o after dummy", intr_error_o, 1);
    // A valid command must wait while the error is held
    issue_cmd('0, '0, spi_host_pkg::DirRdOnly, 1'b0, 1'b0);
    repeat (50) @(negedge clk_i);
    compare("active_o seen while errored", active_seen, 0);
    compare("csb_o low lines while errored", csb_low_seen, 0);
    pulse_ctrl(1'b1, 1'b0, 1'b0);
    await_active(1'b1, "the held command to start");
    await_active(1'b0, "the held command to end");
    compare("csb_o low lines after clear", csb_low_seen, 2'b01);
    read_rx(got);
    compare("rx_data_o after held command", got, 0);
  endtask

  task automatic provoke_fifo_errors();
    logic [7:0] got;
    err_en_i = '0;
    spien_i  = 1'b0;
    for (int i = 0; i < `SPI_TX_DEPTH; i++) begin
      push_tx(next_random());
    end
    compare("tx_qd_o when full", tx_qd_o, `SPI_TX_DEPTH);
    compare("err_status_o before overflow", err_status_o, 0);
    push_tx(next_random());
    compare("err_status_o after overflow", err_status_o, 5'b00010);
    compare("intr_error_o after overflow", intr_error_o, 0);
    read_rx(got);
    compare("err_status_o after underflow", err_status_o, 5'b00110);
    compare("intr_error_o after underflow", intr_error_o, 0);
    pulse_ctrl(1'b1, 1'b0, 1'b1);
    compare("tx_qd_o after soft reset", tx_qd_o, 0);
    compare("err_status_o after clear", err_status_o, 0);
    err_en_i = 5'h1f;
    spien_i  = 1'b1;
  endtask

  task automatic overfill_cmd_queue();
    logic [7:0] got;
    int         n;
    spien_i = 1'b0;
    reset_observers();
    for (int i = 0; i < `SPI_CMD_DEPTH; i++) begin
      issue_cmd('0, '0, spi_host_pkg::DirRdOnly, 1'b0, 1'b0);
    end
    compare("ready_o with queue full", ready_o, 0);
    compare("err_status_o before extra command", err_status_o, 0);
    issue_cmd('0, '0, spi_host_pkg::DirRdOnly, 1'b0, 1'b0);
    compare("err_status_o after extra command", err_status_o, 5'b00001);
    pulse_ctrl(1'b1, 1'b0, 1'b0);
    spien_i = 1'b1;
    n = 0;
    while (!(cs_starts >= `SPI_CMD_DEPTH && !active_o) && n < TimeoutCycles) begin
      @(negedge clk_i);
      n++;
    end
    if (n >= TimeoutCycles) begin
      errors++;
      $display("Timeout at %0t: the queued commands did not all run", $time);
    end
    repeat (100) @(negedge clk_i);
    compare("chip-select low periods", cs_starts, `SPI_CMD_DEPTH);
    compare("ready_o after drain", ready_o, 1);
    compare("rx_qd_o after drain", rx_qd_o, `SPI_CMD_DEPTH);
    for (int i = 0; i < `SPI_CMD_DEPTH; i++) begin
      read_rx(got);
      compare($sformatf("rx_data_o byte %0d", i), got, 0);
    end
  endtask

  task automatic idle_event_irq();
    logic [7:0] got;
    int         n;
    evt_en_i = 6'b100000;
    pulse_ctrl(1'b0, 1'b1, 1'b0);
    issue_cmd('0, '0, spi_host_pkg::DirRdOnly, 1'b0, 1'b0);
    await_active(1'b1, "the event command to start");
    compare("intr_event_o while active", intr_event_o, 0);
    await_active(1'b0, "the event command to end");
    n = 0;
    while (!intr_event_o && n < TimeoutCycles) begin
      @(negedge clk_i);
      n++;
    end
    if (!intr_event_o) begin
      errors++;
      $display("Timeout at %0t: intr_event_o did not rise after the idle edge", $time);
    end
    pulse_ctrl(1'b0, 1'b1, 1'b0);
    compare("intr_event_o after clear", intr_event_o, 0);
    read_rx(got);
    // Same command with every event masked
    evt_en_i = '0;
    issue_cmd('0, '0, spi_host_pkg::DirRdOnly, 1'b0, 1'b0);
    await_active(1'b1, "the masked command to start");
    await_active(1'b0, "the masked command to end");
    repeat (20) @(negedge clk_i);
    compare("intr_event_o with events masked", intr_event_o, 0);
    read_rx(got);
  endtask

  initial begin
    errors       = 0;
    checks       = 0;
    lcg_state    = 32'd33;
    prev_sck     = 1'b0;
    prev_sd      = 1'b0;
    prev_csb     = '1;
    cur_cpol     = 1'b0;
    cur_cpha     = 1'b0;
    reset_observers();
    rst_ni       = 1'b0;
    spien_i      = 1'b0;
    sw_rst_i     = 1'b0;
    cmd_valid_i  = 1'b0;
    csid_i       = '0;
    cmd_len_i    = '0;
    cmd_dir_i    = spi_host_pkg::DirBidir;
    cmd_csaat_i  = 1'b0;
    clkdiv_i     = 8'd1;
    csnlead_i    = 4'd1;
    csntrail_i   = 4'd1;
    csnidle_i    = 4'd1;
    cpol_i       = 1'b0;
    cpha_i       = 1'b0;
    tx_data_i    = '0;
    tx_valid_i   = 1'b0;
    rx_re_i      = 1'b0;
    tx_wm_lvl_i  = 4'd4;
    rx_wm_lvl_i  = 4'd4;
    err_en_i     = 5'h1f;
    evt_en_i     = '0;
    err_clear_i  = 1'b0;
    evt_clear_i  = 1'b0;
    repeat (16) @(posedge clk_i);
    @(negedge clk_i);
    rst_ni  = 1'b1;
    spien_i = 1'b1;

    send_bytes(4, 2'd1, spi_host_pkg::DirBidir, 1'b0, 1'b0);
    send_bytes(3, 2'd0, spi_host_pkg::DirWrOnly, 1'b1, 1'b1);
    receive_zeros(2);
    reject_bad_cmds();
    provoke_fifo_errors();
    overfill_cmd_queue();
    idle_event_irq();

    $display("Checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("RESULT: PASS");
    end else begin
      $display("RESULT: FAIL");
    end
    $finish;
  end

endmodule

//--- verilog.f
+incdir+include
hdl/spi_host_pkg.sv
hdl/spi_host_cmd_queue.sv
hdl/spi_host_data_fifos.sv
hdl/spi_host_core.sv
hdl/spi_host_irq.sv
hdl/spi_host.sv
verif/tb_spi_host.sv
